//--- common/frontend_pkg.sv
package frontend_pkg;

    // Address and instruction width
    localparam int ADDR_W = 32;

    // Default front end geometry
    localparam int DEF_FETCH_WIDTH  = 4;
    localparam int DEF_DECODE_WIDTH = 2;
    // Buffer depth, power of two
    localparam int DEF_IB_DEPTH     = 16;

    // First fetch address out of reset
    localparam logic [ADDR_W-1:0] DEF_RESET_PC = 32'h1c00_0000;

    // One buffered instruction
    typedef struct packed {
        logic [ADDR_W-1:0] pc;
        logic [ADDR_W-1:0] instr;
    } ib_entry_t;

    // Flush causes and targets from the back end
    typedef struct packed {
        // Exception entry, refill flavour selects the TLB refill vector
        logic              excp;
        logic              tlbrefill;
        // Return from exception
        logic              ertn;
        // Idle wakeup
        logic              idle;
        // Execute stage stalled, branch results not yet valid
        logic              ex_stall;
        // Taken branch per execute slot
        logic [1:0]        branch_flag;
        logic [ADDR_W-1:0] eentry;
        logic [ADDR_W-1:0] tlbrentry;
        logic [ADDR_W-1:0] era;
        logic [ADDR_W-1:0] idle_pc;
        logic [ADDR_W-1:0] branch_target0;
        logic [ADDR_W-1:0] branch_target1;
    } redirect_req_t;

endpackage

//--- hw/redirect_unit.sv
`timescale 1ns/1ps

module redirect_unit (
    input  frontend_pkg::redirect_req_t     redirect_i,
    output logic                            flush_o,
    output logic [frontend_pkg::ADDR_W-1:0] next_pc_o
);

    logic branch0_taken;
    logic branch1_taken;

    // Branch outcome is only trusted when execute is moving
    assign branch0_taken = redirect_i.branch_flag[0] & ~redirect_i.ex_stall;
    assign branch1_taken = redirect_i.branch_flag[1] & ~redirect_i.ex_stall;

    assign flush_o = redirect_i.excp
                   | redirect_i.ertn
                   | redirect_i.idle
                   | branch0_taken
                   | branch1_taken;

    // Oldest cause wins
    always_comb begin
        if (redirect_i.excp) begin
            if (redirect_i.tlbrefill) begin
                next_pc_o = redirect_i.tlbrentry;
            end else begin
                next_pc_o = redirect_i.eentry;
            end
        end else if (redirect_i.ertn) begin
            next_pc_o = redirect_i.era;
        end else if (redirect_i.idle) begin
            next_pc_o = redirect_i.idle_pc;
        end else if (branch0_taken) begin
            next_pc_o = redirect_i.branch_target0;
        end else if (branch1_taken) begin
            next_pc_o = redirect_i.branch_target1;
        end else begin
            // No redirect this cycle
            next_pc_o = '0;
        end
    end

endmodule

//--- frontend/fetch_ctrl.sv
`timescale 1ns/1ps

module fetch_ctrl #(
    parameter logic [frontend_pkg::ADDR_W-1:0] RESET_PC    = frontend_pkg::DEF_RESET_PC,
    parameter int                              FETCH_WIDTH = frontend_pkg::DEF_FETCH_WIDTH
) (
    input  logic                                        clk,
    input  logic                                        rst_n_i,
    // Redirect from back end
    input  logic                                        flush_i,
    input  logic [frontend_pkg::ADDR_W-1:0]             next_pc_i,
    // Instruction buffer nearly full
    input  logic                                        stall_i,
    // Instruction memory port
    output logic                                        fetch_req_o,
    output logic [frontend_pkg::ADDR_W-1:0]             fetch_addr_o,
    input  logic                                        fetch_rvalid_i,
    input  logic [FETCH_WIDTH*frontend_pkg::ADDR_W-1:0] fetch_rdata_i,
    // Write port of the instruction buffer
    output logic [FETCH_WIDTH-1:0]                      wr_valid_o,
    output frontend_pkg::ib_entry_t [FETCH_WIDTH-1:0]   wr_entry_o
);

    localparam int OFF_W   = $clog2(FETCH_WIDTH);
    localparam int BLK_LSB = OFF_W + 2;
    localparam logic [frontend_pkg::ADDR_W-1:0] BLK_BYTES =
        frontend_pkg::ADDR_W'(FETCH_WIDTH * 4);

    logic [frontend_pkg::ADDR_W-1:0] pc_q;
    logic                            outstanding_q;
    logic                            discard_q;
    logic                            fetch_en_q;
    logic [frontend_pkg::ADDR_W-1:0] blk_addr;
    logic [OFF_W-1:0]                word_off;
    logic                            rsp_take;

    assign blk_addr = {pc_q[frontend_pkg::ADDR_W-1:BLK_LSB], {BLK_LSB{1'b0}}};
    assign word_off = pc_q[BLK_LSB-1:2];

    // One request in flight at most, none during a redirect or when the buffer is tight
    assign fetch_req_o  = fetch_en_q & ~outstanding_q & ~flush_i & ~stall_i;
    assign fetch_addr_o = blk_addr;

    // Data is kept unless a flush came first or arrives with it
    assign rsp_take = fetch_rvalid_i & outstanding_q & ~discard_q & ~flush_i;

    always_comb begin
        for (int k = 0; k < FETCH_WIDTH; k++) begin
            wr_entry_o[k].pc    = blk_addr + frontend_pkg::ADDR_W'(4 * k);
            wr_entry_o[k].instr =
                fetch_rdata_i[k*frontend_pkg::ADDR_W +: frontend_pkg::ADDR_W];
            // Words below the PC offset are not part of the stream
            wr_valid_o[k] = rsp_take & (OFF_W'(k) >= word_off);
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            pc_q          <= RESET_PC;
            outstanding_q <= 1'b0;
            discard_q     <= 1'b0;
            fetch_en_q    <= 1'b0;
        end else begin
            // Hold off the first request until one edge after reset
            fetch_en_q <= 1'b1;
            if (flush_i) begin
                pc_q          <= next_pc_i;
                // Pending block now stale, wait for it and drop it
                outstanding_q <= outstanding_q & ~fetch_rvalid_i;
                discard_q     <= outstanding_q & ~fetch_rvalid_i;
            end else if (fetch_rvalid_i && outstanding_q) begin
                outstanding_q <= 1'b0;
                discard_q     <= 1'b0;
                if (!discard_q) begin
                    pc_q <= blk_addr + BLK_BYTES;
                end
            end else if (fetch_req_o) begin
                outstanding_q <= 1'b1;
            end
        end
    end

endmodule

//--- frontend/instr_buffer.sv
`timescale 1ns/1ps

module instr_buffer #(
    parameter int IB_DEPTH     = frontend_pkg::DEF_IB_DEPTH,
    parameter int FETCH_WIDTH  = frontend_pkg::DEF_FETCH_WIDTH,
    parameter int DECODE_WIDTH = frontend_pkg::DEF_DECODE_WIDTH
) (
    input  logic                                       clk,
    input  logic                                       rst_n_i,
    input  logic                                       flush_i,
    // From fetch
    input  logic [FETCH_WIDTH-1:0]                     wr_valid_i,
    input  frontend_pkg::ib_entry_t [FETCH_WIDTH-1:0]  wr_entry_i,
    output logic                                       stall_o,
    // To decode, slot 0 oldest
    output logic [DECODE_WIDTH-1:0]                    dec_valid_o,
    output frontend_pkg::ib_entry_t [DECODE_WIDTH-1:0] dec_entry_o,
    input  logic [DECODE_WIDTH-1:0]                    dec_accept_i
);

    localparam int PTR_W = $clog2(IB_DEPTH);
    localparam int CNT_W = PTR_W + 1;

    frontend_pkg::ib_entry_t mem [IB_DEPTH];

    logic [PTR_W-1:0]                  head_q;
    logic [PTR_W-1:0]                  tail_q;
    logic [CNT_W-1:0]                  count_q;
    logic [FETCH_WIDTH-1:0][PTR_W-1:0] wr_pos;
    logic [CNT_W-1:0]                  wr_cnt;
    logic [CNT_W-1:0]                  pop_cnt;
    logic                              pop_run;

    // Pack the valid write slots in order
    always_comb begin
        wr_cnt = '0;
        for (int k = 0; k < FETCH_WIDTH; k++) begin
            wr_pos[k] = wr_cnt[PTR_W-1:0];
            wr_cnt    = wr_cnt + CNT_W'(wr_valid_i[k]);
        end
    end

    // Decode takes a prefix of the offered slots
    always_comb begin
        pop_cnt = '0;
        pop_run = 1'b1;
        for (int j = 0; j < DECODE_WIDTH; j++) begin
            pop_run = pop_run & dec_accept_i[j] & dec_valid_o[j];
            pop_cnt = pop_cnt + CNT_W'(pop_run);
        end
    end

    always_comb begin
        for (int j = 0; j < DECODE_WIDTH; j++) begin
            dec_valid_o[j] = count_q > CNT_W'(j);
            dec_entry_o[j] = mem[head_q + PTR_W'(j)];
        end
    end

    // Keep a full fetch block of room
    assign stall_o = (CNT_W'(IB_DEPTH) - count_q) < CNT_W'(FETCH_WIDTH);

    always_ff @(posedge clk) begin
        for (int k = 0; k < FETCH_WIDTH; k++) begin
            if (wr_valid_i[k]) begin
                mem[tail_q + wr_pos[k]] <= wr_entry_i[k];
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
        end else if (flush_i) begin
            // Everything buffered is on the wrong path
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
        end else begin
            head_q  <= head_q + pop_cnt[PTR_W-1:0];
            tail_q  <= tail_q + wr_cnt[PTR_W-1:0];
            count_q <= count_q + wr_cnt - pop_cnt;
        end
    end

endmodule

//--- hw/fetch_top.sv
`timescale 1ns/1ps

module fetch_top #(
    parameter logic [frontend_pkg::ADDR_W-1:0] RESET_PC     = frontend_pkg::DEF_RESET_PC,
    parameter int                              FETCH_WIDTH  = frontend_pkg::DEF_FETCH_WIDTH,
    parameter int                              DECODE_WIDTH = frontend_pkg::DEF_DECODE_WIDTH,
    parameter int                              IB_DEPTH     = frontend_pkg::DEF_IB_DEPTH
) (
    input  logic                                        clk,
    input  logic                                        rst_n_i,
    // Back end redirect causes
    input  frontend_pkg::redirect_req_t                 redirect_i,
    // Instruction memory
    output logic                                        fetch_req_o,
    output logic [frontend_pkg::ADDR_W-1:0]             fetch_addr_o,
    input  logic                                        fetch_rvalid_i,
    input  logic [FETCH_WIDTH*frontend_pkg::ADDR_W-1:0] fetch_rdata_i,
    // Decode slots
    output logic [DECODE_WIDTH-1:0]                     dec_valid_o,
    output frontend_pkg::ib_entry_t [DECODE_WIDTH-1:0]  dec_entry_o,
    input  logic [DECODE_WIDTH-1:0]                     dec_accept_i
);

    logic                                      flush;
    logic [frontend_pkg::ADDR_W-1:0]           next_pc;
    logic                                      ib_stall;
    logic [FETCH_WIDTH-1:0]                    wr_valid;
    frontend_pkg::ib_entry_t [FETCH_WIDTH-1:0] wr_entry;

    redirect_unit u_redirect_unit (
        .redirect_i (redirect_i),
        .flush_o    (flush),
        .next_pc_o  (next_pc)
    );

    fetch_ctrl #(
        .RESET_PC    (RESET_PC),
        .FETCH_WIDTH (FETCH_WIDTH)
    ) u_fetch_ctrl (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .flush_i        (flush),
        .next_pc_i      (next_pc),
        .stall_i        (ib_stall),
        .fetch_req_o    (fetch_req_o),
        .fetch_addr_o   (fetch_addr_o),
        .fetch_rvalid_i (fetch_rvalid_i),
        .fetch_rdata_i  (fetch_rdata_i),
        .wr_valid_o     (wr_valid),
        .wr_entry_o     (wr_entry)
    );

    instr_buffer #(
        .IB_DEPTH     (IB_DEPTH),
        .FETCH_WIDTH  (FETCH_WIDTH),
        .DECODE_WIDTH (DECODE_WIDTH)
    ) u_instr_buffer (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .flush_i      (flush),
        .wr_valid_i   (wr_valid),
        .wr_entry_i   (wr_entry),
        .stall_o      (ib_stall),
        .dec_valid_o  (dec_valid_o),
        .dec_entry_o  (dec_entry_o),
        .dec_accept_i (dec_accept_i)
    );

endmodule

//--- tb/fetch_top_assert.sv
`timescale 1ns/1ps

module fetch_top_assert #(
    parameter int DECODE_WIDTH = frontend_pkg::DEF_DECODE_WIDTH
) (
    input logic                    clk,
    input logic                    rst_n_i,
    input logic                    fetch_req_i,
    input logic                    fetch_rvalid_i,
    input logic [DECODE_WIDTH-1:0] dec_valid_i
);

    logic pending_q;
    // Number of failed assertions
    int   fail_cnt = 0;

    // Memory port busy from request until its response
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            pending_q <= 1'b0;
        end else if (fetch_req_i) begin
            pending_q <= 1'b1;
        end else if (fetch_rvalid_i) begin
            pending_q <= 1'b0;
        end
    end

    one_outstanding: assert property (@(posedge clk) disable iff (!rst_n_i)
        fetch_req_i |-> !pending_q)
        else begin
            $error("fetch request issued while another is outstanding");
            fail_cnt++;
        end

    slot_order: assert property (@(posedge clk) disable iff (!rst_n_i)
        dec_valid_i[1] |-> dec_valid_i[0])
        else begin
            $error("decode slot 1 valid without slot 0");
            fail_cnt++;
        end

    quiet_after_reset: assert property (@(posedge clk)
        $rose(rst_n_i) |-> !fetch_req_i)
        else begin
            $error("fetch request in the first cycle after reset");
            fail_cnt++;
        end

endmodule

bind fetch_top fetch_top_assert #(
    .DECODE_WIDTH (DECODE_WIDTH)
) u_fetch_top_assert (
    .clk            (clk),
    .rst_n_i        (rst_n_i),
    .fetch_req_i    (fetch_req_o),
    .fetch_rvalid_i (fetch_rvalid_i),
    .dec_valid_i    (dec_valid_o)
);

//--- tb/tb_fetch_top.sv
`timescale 1ns/1ps

module tb_fetch_top;

    localparam int FW = frontend_pkg::DEF_FETCH_WIDTH;
    localparam int DW = frontend_pkg::DEF_DECODE_WIDTH;
    localparam int AW = frontend_pkg::ADDR_W;
    localparam int NUM_ROWS = 10;

    // Per test the redirect held for a cycle, decode behaviour and expected stream
    typedef struct packed {
        frontend_pkg::redirect_req_t req;
        logic [1:0]                  mode;
        logic [7:0]                  n;
        logic [AW-1:0]               first_pc;
        logic                        pend;
    } row_t;

    logic                                  clk = 1'b0;
    logic                                  rst_n = 1'b0;
    frontend_pkg::redirect_req_t           redirect = '0;
    logic                                  fetch_req;
    logic [AW-1:0]                         fetch_addr;
    logic                                  fetch_rvalid = 1'b0;
    logic [FW*AW-1:0]                      fetch_rdata = '0;
    logic [DW-1:0]                         dec_valid;
    frontend_pkg::ib_entry_t [DW-1:0]      dec_entry;
    logic [DW-1:0]                         dec_accept = '0;

    row_t                        rows [NUM_ROWS];
    frontend_pkg::redirect_req_t decoy;
    logic [AW-1:0]               exp_q [$];
    logic [1:0]                  acc_next = 2'b00;
    int                          idle_run = 0;
    int                          cycles = 0;
    int                          cycle_limit = 0;

    // Memory model state
    logic                        req_seen = 1'b0;
    logic [AW-1:0]               req_addr = '0;
    logic                        mem_busy = 1'b0;
    logic [AW-1:0]               mem_addr = '0;
    int                          mem_wait = 0;

    fetch_top UUT (
        .clk            (clk),
        .rst_n_i        (rst_n),
        .redirect_i     (redirect),
        .fetch_req_o    (fetch_req),
        .fetch_addr_o   (fetch_addr),
        .fetch_rvalid_i (fetch_rvalid),
        .fetch_rdata_i  (fetch_rdata),
        .dec_valid_o    (dec_valid),
        .dec_entry_o    (dec_entry),
        .dec_accept_i   (dec_accept)
    );

    always #2 clk = ~clk;

    // Requests are seen mid-cycle and answered 1 to 4 cycles later
    always @(negedge clk) begin
        req_seen = fetch_req;
        req_addr = fetch_addr;
    end

    always @(posedge clk) begin
        fetch_rvalid <= 1'b0;
        if (req_seen) begin
            mem_busy = 1'b1;
            mem_addr = req_addr;
            mem_wait = $urandom_range(3, 0);
        end
        if (mem_busy) begin
            if (mem_wait == 0) begin
                fetch_rvalid <= 1'b1;
                for (int k = 0; k < FW; k++) begin
                    fetch_rdata[k*AW +: AW] <= (mem_addr + 32'(4 * k)) ^ 32'h5a5a_0000;
                end
                mem_busy = 1'b0;
            end else begin
                mem_wait = mem_wait - 1;
            end
        end
    end

    // Flags are {excp, tlbrefill, ertn, idle, ex_stall} and targets spread from base
    function automatic frontend_pkg::redirect_req_t make_redirect(input logic [4:0] flags,
            input logic [1:0] br, input logic [AW-1:0] base);
        frontend_pkg::redirect_req_t r;
        r = '0;
        r.excp           = flags[4];
        r.tlbrefill      = flags[3];
        r.ertn           = flags[2];
        r.idle           = flags[1];
        r.ex_stall       = flags[0];
        r.branch_flag    = br;
        r.tlbrentry      = base + 32'h0000_1000;
        r.eentry         = base + 32'h0000_2000;
        r.era            = base + 32'h0000_3000;
        r.idle_pc        = base + 32'h0000_4000;
        r.branch_target0 = base + 32'h0000_5000;
        r.branch_target1 = base + 32'h0000_6008;
        return r;
    endfunction

    // 0 takes all, 1 random, 2 random with long idle stretches
    function automatic logic [1:0] accept_pattern(input logic [1:0] mode);
        logic [1:0] pat;
        pat = 2'b11;
        if (mode == 2'd1) begin
            pat = 2'($urandom_range(3, 0));
        end else if (mode == 2'd2) begin
            if (idle_run > 0) begin
                idle_run--;
                pat = 2'b00;
            end else if ($urandom_range(7, 0) == 0) begin
                idle_run = int'($urandom_range(30, 10));
                pat = 2'b00;
            end else begin
                pat = 2'($urandom_range(3, 0));
            end
        end
        return pat;
    endfunction

    task automatic stop_with_failure(input string msg);
        $display("%s", msg);
        $display("=== FAIL ===");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
            input logic [31:0] expected);
        if (actual !== expected) begin
            stop_with_failure($sformatf("FAILED at %0d ns: %s = %h, expected %h",
                $time, name, actual, expected));
        end
    endtask

    // Drive at the rising edge, check and plan at the falling edge
    task automatic tick(input frontend_pkg::redirect_req_t req, input logic [1:0] mode);
        int          avail;
        logic [1:0]  want;
        logic [31:0] exp_pc;
        @(posedge clk);
        redirect   <= req;
        dec_accept <= acc_next;
        @(negedge clk);
        cycles++;
        if (cycles > cycle_limit) begin
            stop_with_failure($sformatf("Timeout after %0d cycles with %0d instructions missing",
                cycles, exp_q.size()));
        end
        if (UUT.u_fetch_top_assert.fail_cnt != 0) begin
            stop_with_failure("An assertion on the fetch_top ports failed");
        end
        avail = int'(dec_valid[0]) + int'(dec_valid[1]);
        for (int j = 0; j < DW; j++) begin
            if (dec_accept[j]) begin
                check_value($sformatf("dec_valid_o[%0d]", j), 32'(dec_valid[j]), 32'd1);
                exp_pc = exp_q.pop_front();
                check_value($sformatf("dec_entry_o[%0d].pc", j), dec_entry[j].pc, exp_pc);
                check_value($sformatf("dec_entry_o[%0d].instr", j), dec_entry[j].instr,
                    exp_pc ^ 32'h5a5a_0000);
                avail--;
            end
        end
        // Only entries surely still offered next cycle may be taken
        if (req != '0) begin
            avail = 0;
        end
        if (avail > exp_q.size()) begin
            avail = exp_q.size();
        end
        want = accept_pattern(mode);
        acc_next[0] = want[0] && avail >= 1;
        acc_next[1] = acc_next[0] && want[1] && avail >= 2;
    endtask

    initial begin
        void'($urandom(32'hd246_ccc4));
        rows[0] = '{make_redirect(5'b00000, 2'b00, 32'h0), 2'd0, 8'd24, 32'h1c00_0000, 1'b0};
        rows[1] = '{make_redirect(5'b00000, 2'b00, 32'h0), 2'd2, 8'd40, 32'h1c00_0060, 1'b0};
        rows[2] = '{make_redirect(5'b11100, 2'b01, 32'h1c10_0000), 2'd1, 8'd12,
            32'h1c10_1000, 1'b0};
        rows[3] = '{make_redirect(5'b10110, 2'b11, 32'h1c20_0000), 2'd1, 8'd8,
            32'h1c20_2000, 1'b0};
        rows[4] = '{make_redirect(5'b00110, 2'b11, 32'h1c30_0000), 2'd0, 8'd8,
            32'h1c30_3000, 1'b0};
        // Refill flag alone does not count as an exception
        rows[5] = '{make_redirect(5'b01010, 2'b01, 32'h1c40_0000), 2'd1, 8'd8,
            32'h1c40_4000, 1'b0};
        rows[6] = '{make_redirect(5'b00000, 2'b11, 32'h1c50_0000), 2'd1, 8'd8,
            32'h1c50_5000, 1'b0};
        rows[7] = '{make_redirect(5'b00000, 2'b10, 32'h1c60_0000), 2'd0, 8'd10,
            32'h1c60_6008, 1'b0};
        // Stalled execute so the stream carries on after row 7
        rows[8] = '{make_redirect(5'b00001, 2'b11, 32'h1c70_0000), 2'd2, 8'd12,
            32'h1c60_6030, 1'b0};
        rows[9] = '{make_redirect(5'b00100, 2'b00, 32'h1c80_0000), 2'd2, 8'd16,
            32'h1c80_3000, 1'b1};
        decoy = make_redirect(5'b00000, 2'b01, 32'h2000_0000);
        for (int r = 0; r < NUM_ROWS; r++) begin
            cycle_limit += 40 * int'(rows[r].n);
        end

        repeat (5) @(posedge clk);
        rst_n <= 1'b1;

        for (int r = 0; r < NUM_ROWS; r++) begin
            if (rows[r].pend) begin
                // Steer fetch to a decoy block, then redirect while it is in flight
                tick(decoy, 2'd0);
                tick('0, 2'd0);
                check_value("dec_valid_o", 32'(dec_valid), 32'd0);
                while (!fetch_req) begin
                    tick('0, 2'd0);
                end
            end
            for (int i = 0; i < int'(rows[r].n); i++) begin
                exp_q.push_back(rows[r].first_pc + 32'(4 * i));
            end
            tick(rows[r].req, rows[r].mode);
            while (exp_q.size() > 0) begin
                tick('0, rows[r].mode);
            end
        end

        $display("=== PASS ===");
        $finish;
    end

endmodule

//--- verilog.f
common/frontend_pkg.sv
hw/redirect_unit.sv
frontend/fetch_ctrl.sv
frontend/instr_buffer.sv
hw/fetch_top.sv
tb/fetch_top_assert.sv
tb/tb_fetch_top.sv

//--- Makefile
TOP := tb_fetch_top
LOG := sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --top-module $(TOP) -f verilog.f -Mdir obj_dir

run: compile
	-./obj_dir/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "=== FAIL ===" $(LOG); then echo "Simulation failed"; exit 1; fi
	@grep -q "=== PASS ===" $(LOG) || (echo "Simulation did not complete"; exit 1)

clean:
	rm -rf obj_dir $(LOG)
